// ==== include/conv_params.svh ====
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

//////////////////////////////////////////////////
// screen geometry
//////////////////////////////////////////////////

// pixels per line
`define SCREEN_W 16
// lines per frame
`define SCREEN_H 12

//////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////

// unsigned camera pixel
`define PIXEL_W 8
// signed kernel coefficient
`define COEF_W 4
// signed adder result, wide enough for any 3x3 sum
`define SUM_W 16

// window side in pixels
`define KERNEL_DIM 3
// kernels in the bank
`define NUM_KERNELS 2

`endif

// ==== logic/conv_top.sv ====
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_top
  import stream_pkg::*;
(
  input  logic                              clock,
  input  logic                              rst,
  // raster input
  input  logic                              pixel_valid,
  input  coord_x_t                          screen_x,
  input  coord_y_t                          screen_y,
  input  pixel_t                            pixel,
  // feature map output
  output logic                              out_valid,
  output coord_x_t                          out_x,
  output coord_y_t                          out_y,
  output logic [`NUM_KERNELS*`PIXEL_W-1:0] out_pixels
);

  // decode stage wires
  logic     shift;
  coord_x_t col;

  // stage buses
  window_if  win_bus ();
  feature_if feat_bus ();

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////

  window_ctrl window_ctrl_inst (
    .clock       (clock),
    .rst         (rst),
    .pixel_valid (pixel_valid),
    .screen_x    (screen_x),
    .screen_y    (screen_y),
    .shift       (shift),
    .col         (col),
    .win         (win_bus.ctrl)
  );

  window_buffer window_buffer_inst (
    .clock (clock),
    .pixel (pixel),
    .shift (shift),
    .col   (col),
    .win   (win_bus.buffer)
  );

  // execute
  mult_adder mult_adder_inst (
    .clock (clock),
    .rst   (rst),
    .win   (win_bus.sink),
    .feat  (feat_bus.source)
  );

  // result
  rect_linear rect_linear_inst (
    .clock      (clock),
    .rst        (rst),
    .feat       (feat_bus.sink),
    .out_valid  (out_valid),
    .out_x      (out_x),
    .out_y      (out_y),
    .out_pixels (out_pixels)
  );

endmodule

// ==== logic/feature_if.sv ====
`timescale 1ns/1ps

// per-kernel sums from the execute stage
interface feature_if
  import stream_pkg::*;
  import kernel_pkg::*;
();

  logic     valid;
  // bottom-right coordinate of the source window
  coord_x_t x;
  coord_y_t y;
  // raw tree sums, kernel 0 lowest
  sum_vec_t sums;

  modport source (output valid, output x, output y, output sums);
  modport sink (input valid, input x, input y, input sums);

endinterface

// ==== logic/kernel_pkg.sv ====
`include "conv_params.svh"

// types and coefficients of the kernel bank
package kernel_pkg;

  import stream_pkg::*;

  // signed kernel weight
  typedef logic signed [`COEF_W-1:0] coef_t;

  // nine weights in window tap order
  typedef coef_t [WIN_TAPS-1:0] kernel_t;

  // one adder tree result
  typedef logic signed [`SUM_W-1:0] sum_t;

  // one sum per kernel, kernel 0 in the low bits
  typedef sum_t [`NUM_KERNELS-1:0] sum_vec_t;

  //////////////////////////////////////////////////
  // fixed kernel table
  //////////////////////////////////////////////////

  // each pattern lists tap 8 first, tap 0 last
  localparam kernel_t KERNELS [`NUM_KERNELS] = '{
    // kernel 0 laplacian edge detect
    // sign flipped so the centre weight fits in 4 bits
    '{ 1,  1,  1,
       1, -8,  1,
       1,  1,  1 },
    // kernel 1 horizontal sobel
    // bottom row positive, top row negative
    '{ 1,  2,  1,
       0,  0,  0,
      -1, -2, -1 }
  };

endpackage

// ==== logic/mult_adder.sv ====
`timescale 1ns/1ps
`include "conv_params.svh"

module mult_adder
  import stream_pkg::*;
  import kernel_pkg::*;
(
  input  logic      clock,
  input  logic      rst,
  window_if.sink    win,
  feature_if.source feat
);

  // tags beside the product registers
  logic     valid_s1;
  coord_x_t x_s1;
  coord_y_t y_s1;

  // combinational sum of each kernel
  sum_vec_t tree_vec;

  //////////////////////////////////////////////////
  // valid and coordinate delay
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (rst) begin
      valid_s1   <= 1'b0;
      feat.valid <= 1'b0;
    end else begin
      valid_s1   <= win.valid;
      feat.valid <= valid_s1;
    end
  end

  // coordinates follow the same two steps
  always_ff @(posedge clock) begin
    x_s1   <= win.x;
    y_s1   <= win.y;
    feat.x <= x_s1;
    feat.y <= y_s1;
  end

  //////////////////////////////////////////////////
  // one tree per kernel
  //////////////////////////////////////////////////

  for (genvar k = 0; k < `NUM_KERNELS; k++) begin : g_tree
    sum_t prod_q [WIN_TAPS];

    // stage one
    // pixel zero-extended before the signed multiply
    always_ff @(posedge clock) begin
      for (int t = 0; t < WIN_TAPS; t++) begin
        prod_q[t] <= sum_t'($signed({1'b0, win.win[t]})) * sum_t'(KERNELS[k][t]);
      end
    end

    // add all nine products
    always_comb begin
      tree_vec[k] = '0;
      for (int t = 0; t < WIN_TAPS; t++) begin
        tree_vec[k] = tree_vec[k] + prod_q[t];
      end
    end
  end

  // stage two registers every kernel sum
  always_ff @(posedge clock) begin
    feat.sums <= tree_vec;
  end

endmodule

// ==== logic/rect_linear.sv ====
`timescale 1ns/1ps
`include "conv_params.svh"

module rect_linear
  import stream_pkg::*;
  import kernel_pkg::*;
(
  input  logic                              clock,
  input  logic                              rst,
  feature_if.sink                           feat,
  output logic                              out_valid,
  output coord_x_t                          out_x,
  output coord_y_t                          out_y,
  output logic [`NUM_KERNELS*`PIXEL_W-1:0] out_pixels
);

  // brightest pixel expressed as a sum
  localparam sum_t PIX_MAX = sum_t'((1 << `PIXEL_W) - 1);

  pixel_t [`NUM_KERNELS-1:0] clamped;

  // relu then saturate to pixel range
  always_comb begin
    for (int k = 0; k < `NUM_KERNELS; k++) begin
      if (feat.sums[k] < 0) begin
        clamped[k] = '0;
      end else if (feat.sums[k] > PIX_MAX) begin
        clamped[k] = '1;
      end else begin
        clamped[k] = feat.sums[k][`PIXEL_W-1:0];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= feat.valid;
    end
  end

  // result payload
  always_ff @(posedge clock) begin
    out_x      <= feat.x;
    out_y      <= feat.y;
    out_pixels <= clamped;
  end

endmodule

// ==== logic/stream_pkg.sv ====
`include "conv_params.svh"

// types that describe the raster video stream
package stream_pkg;

  // one pixel of the incoming raster
  typedef logic [`PIXEL_W-1:0] pixel_t;

  // screen column
  typedef logic [$clog2(`SCREEN_W)-1:0] coord_x_t;

  // screen row
  typedef logic [$clog2(`SCREEN_H)-1:0] coord_y_t;

  // pixels in one window
  localparam int WIN_TAPS = `KERNEL_DIM * `KERNEL_DIM;

  // 3x3 window
  // tap 0 is top-left, row-major order
  // tap WIN_TAPS-1 is the newest pixel
  typedef pixel_t [WIN_TAPS-1:0] window_t;

endpackage

// ==== logic/window_buffer.sv ====
`timescale 1ns/1ps
`include "conv_params.svh"

module window_buffer
  import stream_pkg::*;
(
  input  logic     clock,
  input  pixel_t   pixel,
  input  logic     shift,
  input  coord_x_t col,
  window_if.buffer win
);

  //////////////////////////////////////////////////
  // line memories
  //////////////////////////////////////////////////

  // two lines above the current pixel
  pixel_t line_top [`SCREEN_W];
  pixel_t line_mid [`SCREEN_W];

  // column read out of both lines
  pixel_t top_rd;
  pixel_t mid_rd;

  // 3x3 register window
  window_t window_q;

  // asynchronous read at the current column
  assign top_rd = line_top[col];
  assign mid_rd = line_mid[col];

  // each line moves up by one at this column
  // middle line takes the new pixel
  always_ff @(posedge clock) begin
    if (shift) begin
      line_top[col] <= mid_rd;
      line_mid[col] <= pixel;
    end
  end

  //////////////////////////////////////////////////
  // sliding window
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (shift) begin
      // every row moves one tap left
      for (int r = 0; r < `KERNEL_DIM; r++) begin
        for (int c = 0; c < `KERNEL_DIM - 1; c++) begin
          window_q[r*`KERNEL_DIM + c] <= window_q[r*`KERNEL_DIM + c + 1];
        end
      end
      // new column enters on the right
      window_q[`KERNEL_DIM - 1]   <= top_rd;
      window_q[2*`KERNEL_DIM - 1] <= mid_rd;
      window_q[WIN_TAPS - 1]      <= pixel;
    end
  end

  assign win.win = window_q;

endmodule

// ==== logic/window_ctrl.sv ====
`timescale 1ns/1ps
`include "conv_params.svh"

module window_ctrl
  import stream_pkg::*;
(
  input  logic     clock,
  input  logic     rst,
  input  logic     pixel_valid,
  input  coord_x_t screen_x,
  input  coord_y_t screen_y,
  output logic     shift,
  output coord_x_t col,
  window_if.ctrl   win
);

  // first column and row that close a full window
  localparam coord_x_t FIRST_X = coord_x_t'(`KERNEL_DIM - 1);
  localparam coord_y_t FIRST_Y = coord_y_t'(`KERNEL_DIM - 1);

  logic x_ok;
  logic y_ok;
  logic full_window;

  //////////////////////////////////////////////////
  // position decode
  //////////////////////////////////////////////////

  // enough columns to the left in this line
  assign x_ok = (screen_x >= FIRST_X);
  // two finished lines above
  assign y_ok = (screen_y >= FIRST_Y);
  assign full_window = x_ok && y_ok;

  // buffer steps on every accepted pixel
  assign shift = pixel_valid;
  // line memories indexed by column
  assign col = screen_x;

  //////////////////////////////////////////////////
  // window tagging
  //////////////////////////////////////////////////

  // valid lines up with the window register update
  always_ff @(posedge clock) begin
    if (rst) begin
      win.valid <= 1'b0;
    end else begin
      win.valid <= pixel_valid && full_window;
    end
  end

  // coordinates held until the next pixel
  always_ff @(posedge clock) begin
    if (pixel_valid) begin
      win.x <= screen_x;
      win.y <= screen_y;
    end
  end

endmodule

// ==== logic/window_if.sv ====
`timescale 1ns/1ps

// 3x3 window from the decode stage
interface window_if
  import stream_pkg::*;
();

  // one strobe per complete window
  logic     valid;
  // window pixels, tap 0 top-left
  window_t  win;
  // bottom-right pixel of the window
  coord_x_t x;
  coord_y_t y;

  // window control tags the window
  modport ctrl (output valid, output x, output y);
  // buffer supplies the pixels
  modport buffer (output win);
  // execute stage reads everything
  modport sink (input valid, input win, input x, input y);

endinterface

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the convolution testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module conv_tb \
  -f vlog.f --Mdir obj_dir -o conv_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/conv_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" "$LOG"; then
  echo "simulation result: pass"
  exit 0
else
  echo "simulation result: fail"
  exit 1
fi

// ==== test/conv_tb.sv ====
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_tb
  import stream_pkg::*;
  import kernel_pkg::*;
();

  localparam int OUT_W = `NUM_KERNELS * `PIXEL_W;
  // windows per frame, border rows and columns excluded
  localparam int WIN_PER_FRAME = (`SCREEN_W - 2) * (`SCREEN_H - 2);
  localparam int NUM_FRAMES = 8;
  localparam int MAX_GAP = 3;
  localparam int PERIOD_NS = 40;
  localparam int RESET_CYCLES = 16;
  // worst case stimulus time, doubled, plus reset
  localparam longint WATCHDOG_NS = 2 * NUM_FRAMES * `SCREEN_W * `SCREEN_H * (MAX_GAP + 1)
                                   * PERIOD_NS + RESET_CYCLES * PERIOD_NS;

  // one expected output of the model
  typedef struct packed {
    coord_x_t         x;
    coord_y_t         y;
    logic [OUT_W-1:0] pixels;
    logic [31:0]      cycle;
  } expect_t;

  logic             clock;
  logic             rst;
  logic             pixel_valid;
  coord_x_t         screen_x;
  coord_y_t         screen_y;
  pixel_t           pixel;
  logic             out_valid;
  coord_x_t         out_x;
  coord_y_t         out_y;
  logic [OUT_W-1:0] out_pixels;

  // model state
  pixel_t      frame [`SCREEN_H][`SCREEN_W];
  expect_t     expect_q [$];
  int unsigned cycle = 0;
  int unsigned lcg_state = 15881;
  string       cur_test = "reset";

  // scoreboard counters
  int data_errors = 0;
  int timing_errors = 0;
  int protocol_errors = 0;
  int out_count = 0;
  int zero_seen = 0;
  int max_seen = 0;

  conv_top dut_i (
    .clock       (clock),
    .rst         (rst),
    .pixel_valid (pixel_valid),
    .screen_x    (screen_x),
    .screen_y    (screen_y),
    .pixel       (pixel),
    .out_valid   (out_valid),
    .out_x       (out_x),
    .out_y       (out_y),
    .out_pixels  (out_pixels)
  );

  always #20 clock = ~clock;

  // posedge count, read only on falling edges
  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  //////////////////////////////////////////////////
  // random source and reference model
  //////////////////////////////////////////////////

  function automatic int unsigned rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 8;
  endfunction

  // relu with saturation to the pixel range
  function automatic pixel_t clamp_pixel(input int s);
    if (s < 0) begin
      return '0;
    end
    if (s > 255) begin
      return 8'd255;
    end
    return pixel_t'(s);
  endfunction

  // every kernel over the window ending at (x, y)
  function automatic logic [OUT_W-1:0] model_pixels(input int x, input int y);
    logic [OUT_W-1:0] result;
    int s;
    int r;
    int c;
    result = '0;
    for (int k = 0; k < `NUM_KERNELS; k++) begin
      s = 0;
      for (int t = 0; t < WIN_TAPS; t++) begin
        r = t / `KERNEL_DIM;
        c = t % `KERNEL_DIM;
        s += int'(frame[y - 2 + r][x - 2 + c]) * int'(KERNELS[k][t]);
      end
      result[k*`PIXEL_W +: `PIXEL_W] = clamp_pixel(s);
    end
    return result;
  endfunction

  //////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////

  // no strobe, junk on the data lines
  task automatic idle_cycle();
    pixel_valid = 1'b0;
    pixel = pixel_t'(rand_next());
    @(negedge clock);
  endtask

  task automatic send_pixel(input int x, input int y, input pixel_t p);
    expect_t e;
    pixel_valid = 1'b1;
    screen_x = coord_x_t'(x);
    screen_y = coord_y_t'(y);
    pixel = p;
    frame[y][x] = p;
    if (x >= 2 && y >= 2) begin
      e.x = coord_x_t'(x);
      e.y = coord_y_t'(y);
      e.pixels = model_pixels(x, y);
      // sampled at the next rising edge
      e.cycle = cycle + 1;
      expect_q.push_back(e);
    end
    @(negedge clock);
  endtask

  // mode 0 random, 1 bright dots on dark, 2 dark dots on bright
  task automatic run_frame(input int max_gap, input int mode);
    int unsigned r;
    pixel_t p;
    for (int y = 0; y < `SCREEN_H; y++) begin
      for (int x = 0; x < `SCREEN_W; x++) begin
        if (max_gap > 0) begin
          repeat (rand_next() % (max_gap + 1)) idle_cycle();
        end
        r = rand_next();
        case (mode)
          1: p = (r % 7 == 0) ? pixel_t'(255) : pixel_t'(r % 16);
          2: p = (r % 7 == 0) ? pixel_t'(0) : pixel_t'(240 + r % 16);
          default: p = pixel_t'(r);
        endcase
        send_pixel(x, y, p);
      end
    end
    pixel_valid = 1'b0;
  endtask

  // drain the pipeline, then check the output count
  task automatic finish_frames(input int frames);
    int want;
    while (expect_q.size() != 0) begin
      @(negedge clock);
    end
    repeat (4) idle_cycle();
    want = frames * WIN_PER_FRAME;
    assert (out_count == want) else begin
      $display("[ERROR] %s: output count expected %0d actual %0d", cur_test, want, out_count);
      protocol_errors++;
    end
    out_count = 0;
  endtask

  //////////////////////////////////////////////////
  // monitor
  //////////////////////////////////////////////////

  always @(negedge clock) begin
    expect_t e;
    if (rst) begin
      assert (!out_valid) else begin
        $display("out_valid went high during reset in test %s", cur_test);
        protocol_errors++;
      end
    end else if (out_valid) begin
      out_count++;
      if (expect_q.size() == 0) begin
        $display("output at x %0d y %0d with no window strobed in test %s",
                 out_x, out_y, cur_test);
        protocol_errors++;
      end else begin
        e = expect_q.pop_front();
        assert (out_x == e.x) else begin
          $display("[ERROR] %s: x expected %0d actual %0d", cur_test, e.x, out_x);
          data_errors++;
        end
        assert (out_y == e.y) else begin
          $display("[ERROR] %s: y expected %0d actual %0d", cur_test, e.y, out_y);
          data_errors++;
        end
        assert (out_pixels == e.pixels) else begin
          $display("[ERROR] %s: pixels expected %h actual %h", cur_test, e.pixels, out_pixels);
          data_errors++;
        end
        // three edges after the sampling edge
        assert (cycle == e.cycle + 3) else begin
          $display("[ERROR] %s: output cycle expected %0d actual %0d",
                   cur_test, e.cycle + 3, cycle);
          timing_errors++;
        end
        if (out_pixels == e.pixels) begin
          for (int k = 0; k < `NUM_KERNELS; k++) begin
            if (e.pixels[k*`PIXEL_W +: `PIXEL_W] == 0) zero_seen++;
            if (e.pixels[k*`PIXEL_W +: `PIXEL_W] == 255) max_seen++;
          end
        end
      end
    end
  end

  // ends a run that stops making progress
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns in test %s", WATCHDOG_NS, cur_test);
    $display("test failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    clock = 1'b0;
    rst = 1'b1;
    pixel_valid = 1'b0;
    screen_x = '0;
    screen_y = '0;
    pixel = '0;
    // full-window strobes that reset must swallow
    pixel_valid = 1'b1;
    repeat (RESET_CYCLES) begin
      screen_x = coord_x_t'(2 + rand_next() % (`SCREEN_W - 2));
      screen_y = coord_y_t'(2 + rand_next() % (`SCREEN_H - 2));
      pixel = pixel_t'(rand_next());
      @(negedge clock);
    end
    pixel_valid = 1'b0;
    rst = 1'b0;

    cur_test = "random_gaps";
    run_frame(MAX_GAP, 0);
    run_frame(MAX_GAP, 0);
    finish_frames(2);

    cur_test = "back_to_back";
    run_frame(0, 0);
    finish_frames(1);

    // only the clamp frames count toward the extremes
    zero_seen = 0;
    max_seen = 0;
    cur_test = "clamp_bright";
    run_frame(1, 1);
    finish_frames(1);
    cur_test = "clamp_dark";
    run_frame(1, 2);
    finish_frames(1);
    assert (zero_seen > 0 && max_seen > 0) else begin
      $display("clamp frames did not give both 0 and 255 outputs");
      protocol_errors++;
    end

    // stale lines carried across frame starts
    cur_test = "multi_frame";
    run_frame(1, 0);
    run_frame(0, 0);
    run_frame(2, 0);
    finish_frames(3);

    if (expect_q.size() != 0) begin
      $display("%0d expected outputs never appeared", expect_q.size());
      protocol_errors++;
    end
    $display("errors: data %0d, timing %0d, protocol %0d",
             data_errors, timing_errors, protocol_errors);
    if (data_errors + timing_errors + protocol_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+include
logic/stream_pkg.sv
logic/kernel_pkg.sv
logic/window_if.sv
logic/feature_if.sv
logic/window_ctrl.sv
logic/window_buffer.sv
logic/mult_adder.sv
logic/rect_linear.sv
logic/conv_top.sv
test/conv_tb.sv
